// ==== cache_geom_pkg.sv ====
package cache_geom_pkg;

    // processor address counts halfwords, not bytes
    localparam int PROC_ADDR_W = 31;

    // one cache line, four 32-bit words
    localparam int LINE_W = 128;

    // halfword slots in one line
    localparam int HW_PER_LINE = 8;

    // halfword offset bits inside a line
    localparam int OFFSET_W = 3;

    // line address seen by memory
    // processor address without the offset bits
    localparam int MEM_ADDR_W = PROC_ADDR_W - OFFSET_W;

endpackage

// ==== fetch_pkg.sv ====
package fetch_pkg;

    // RVC parcel size
    localparam int HALF_W = 16;

    // window returned to the fetch unit, two parcels
    localparam int WORD_W = 2 * HALF_W;

    // low two bits of a 32-bit encoding
    // anything else is a compressed instruction
    localparam logic [1:0] FULL_SIZE_OPCODE = 2'b11;

endpackage

// ==== cache_sram_2way.sv ====
`timescale 1ns/1ns

module cache_sram_2way #(
    parameter int SET_IDX_W = 2
) (
    input  logic                                  clk,
    input  logic                                  proc_reset_i,

    // line address and refill port
    input  logic [cache_geom_pkg::MEM_ADDR_W-1:0] addr_i,
    input  logic                                  write_i,
    input  logic [cache_geom_pkg::LINE_W-1:0]     wline_i,

    // lookup result
    output logic [cache_geom_pkg::LINE_W-1:0]     rline_o,
    output logic                                  hit_o
);

    import cache_geom_pkg::*;

    localparam int TAG_W = PROC_ADDR_W - OFFSET_W - SET_IDX_W;
    localparam int SETS  = 1 << SET_IDX_W;

    // per set, one valid bit per way
    logic [SETS-1:0][1:0]  valid_q;
    // per set, the way to replace next
    logic [SETS-1:0]       lru_q;
    logic [TAG_W-1:0]      tag_q  [2][SETS];
    logic [LINE_W-1:0]     line_q [2][SETS];

    logic [SET_IDX_W-1:0]  idx;
    logic [TAG_W-1:0]      tag;
    logic [1:0]            hit_way;
    logic                  victim;

    // low bits pick the set, the rest is compared
    assign idx = addr_i[SET_IDX_W-1:0];
    assign tag = addr_i[SET_IDX_W +: TAG_W];

    // tag compare on both ways in parallel
    assign hit_way[0] = valid_q[idx][0] && (tag_q[0][idx] == tag);
    assign hit_way[1] = valid_q[idx][1] && (tag_q[1][idx] == tag);
    assign hit_o      = |hit_way;

    // way 0 is returned on a miss, the controller ignores it then
    assign rline_o = hit_way[1] ? line_q[1][idx] : line_q[0][idx];

    // refill target
    // empty ways go first, so a cold set never evicts
    always_comb begin
        if (!valid_q[idx][0]) begin
            victim = 1'b0;
        end else if (!valid_q[idx][1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[idx];
        end
    end

    // valid and lru bookkeeping
    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else if (write_i) begin
            valid_q[idx][victim] <= 1'b1;
            // freshly filled way is most recent
            lru_q[idx]           <= ~victim;
        end else if (hit_o) begin
            // other way becomes the replacement candidate
            lru_q[idx] <= ~hit_way[1];
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (write_i) begin
            tag_q[victim][idx]  <= tag;
            line_q[victim][idx] <= wline_i;
        end
    end

    // refill only happens on a miss, so one line never sits in both ways
    a_single_way_hit: assert property (@(posedge clk) disable iff (proc_reset_i)
        !(hit_way[0] && hit_way[1]));

endmodule

// ==== fetch_align.sv ====
`timescale 1ns/1ns

module fetch_align (
    input  logic [cache_geom_pkg::LINE_W-1:0]   line_i,
    input  logic [cache_geom_pkg::OFFSET_W-1:0] offset_i,
    output logic [fetch_pkg::WORD_W-1:0]        window_o,
    output logic                                compressed_o,
    output logic                                cross_o
);

    import cache_geom_pkg::*;
    import fetch_pkg::*;

    // last halfword slot of a line
    localparam logic [OFFSET_W-1:0] LAST_HW = OFFSET_W'(HW_PER_LINE - 1);

    // line padded with one zero halfword on top
    logic [LINE_W+HALF_W-1:0] ext_line;
    logic [WORD_W-1:0]        raw_window;
    logic                     full_size;
    logic                     last_slot;

    // halfword h sits at bits 16h..16h+15
    // the zero pad supplies the upper half at the last slot
    assign ext_line   = {{HALF_W{1'b0}}, line_i};
    assign raw_window = ext_line[HALF_W*offset_i +: WORD_W];

    // encoding check on the first parcel only
    assign full_size = (raw_window[1:0] == FULL_SIZE_OPCODE);
    assign last_slot = (offset_i == LAST_HW);

    always_comb begin
        if (full_size) begin
            window_o = raw_window;
        end else begin
            // compressed, upper parcel belongs to the next instruction
            window_o = {{HALF_W{1'b0}}, raw_window[HALF_W-1:0]};
        end
    end

    assign compressed_o = !full_size;

    // 32-bit instruction spilling into the next line
    assign cross_o = last_slot && full_size;

endmodule

// ==== icache_controller.sv ====
`timescale 1ns/1ns

module icache_controller #(
    parameter int SET_IDX_W = 2
) (
    input  logic                                   clk,
    input  logic                                   proc_reset_i,

    // fetch unit
    input  logic                                   proc_read_i,
    input  logic [cache_geom_pkg::PROC_ADDR_W-1:0] proc_addr_i,
    output logic [fetch_pkg::WORD_W-1:0]           proc_rdata_o,
    output logic                                   proc_compressed_o,
    output logic                                   proc_stall_o,

    // memory
    output logic                                   mem_read_o,
    output logic [cache_geom_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
    input  logic [cache_geom_pkg::LINE_W-1:0]      mem_rdata_i,
    input  logic                                   mem_ready_i,

    // storage
    output logic [cache_geom_pkg::MEM_ADDR_W-1:0]  sram_addr_o,
    output logic                                   sram_write_o,
    output logic [cache_geom_pkg::LINE_W-1:0]      sram_wline_o,
    input  logic                                   sram_hit_i,
    input  logic [cache_geom_pkg::LINE_W-1:0]      sram_line_i,

    // aligner
    output logic [cache_geom_pkg::OFFSET_W-1:0]    fa_offset_o,
    input  logic [fetch_pkg::WORD_W-1:0]           fa_window_i,
    input  logic                                   fa_compressed_i,
    input  logic                                   fa_cross_i
);

    import cache_geom_pkg::*;
    import fetch_pkg::*;

    localparam int TAG_W = PROC_ADDR_W - OFFSET_W - SET_IDX_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_NEXTLINE,
        S_ALLOCATE,
        S_READY
    } state_t;

    state_t                state_q;
    state_t                state_d;
    // set while working on the line after the processor's line
    logic                  next_q;
    logic                  next_d;
    logic                  mem_read_q;
    // halfword 7 of the first line in a crossing
    logic [HALF_W-1:0]     carry_q;

    logic [TAG_W-1:0]      proc_tag;
    logic [SET_IDX_W-1:0]  proc_index;
    logic [MEM_ADDR_W-1:0] proc_line;
    logic [MEM_ADDR_W-1:0] sram_addr;
    logic                  serve;

    // address split into tag and set index
    // offset goes to the aligner
    assign proc_tag    = proc_addr_i[PROC_ADDR_W-1 -: TAG_W];
    assign proc_index  = proc_addr_i[OFFSET_W +: SET_IDX_W];
    assign proc_line   = {proc_tag, proc_index};
    assign fa_offset_o = proc_addr_i[OFFSET_W-1:0];

    // crossing states look at the following line
    // a carry out of the index moves into the tag
    assign sram_addr   = proc_line + {{(MEM_ADDR_W-1){1'b0}}, next_q};
    assign sram_addr_o = sram_addr;

    always_comb begin
        state_d = state_q;
        next_d  = next_q;
        case (state_q)
            S_IDLE: begin
                if (proc_read_i && !sram_hit_i) begin
                    state_d = S_ALLOCATE;
                end else if (proc_read_i && fa_cross_i) begin
                    // own line present so go for the next one
                    state_d = S_NEXTLINE;
                    next_d  = 1'b1;
                end
            end
            S_NEXTLINE: begin
                state_d = sram_hit_i ? S_READY : S_ALLOCATE;
            end
            S_ALLOCATE: begin
                // wait here as long as memory needs
                if (mem_ready_i) begin
                    state_d = S_READY;
                end
            end
            S_READY: begin
                state_d = S_IDLE;
                next_d  = 1'b0;
            end
            default: begin
                state_d = S_IDLE;
                next_d  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset_i) begin
            state_q    <= S_IDLE;
            next_q     <= 1'b0;
            mem_read_q <= 1'b0;
        end else begin
            state_q <= state_d;
            next_q  <= next_d;
            // request drops after the ready cycle
            // and rises on the move into ALLOCATE
            if (mem_read_q && mem_ready_i) begin
                mem_read_q <= 1'b0;
            end else if (state_q != S_ALLOCATE && state_d == S_ALLOCATE) begin
                mem_read_q <= 1'b1;
            end
        end
    end

    // latch the low parcel before the lookup moves on
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && state_d == S_NEXTLINE) begin
            carry_q <= sram_line_i[LINE_W-1 -: HALF_W];
        end
    end

    assign mem_read_o = mem_read_q;
    assign mem_addr_o = sram_addr;

    // line lands in storage on the ready edge
    // so READY already hits
    assign sram_write_o = (state_q == S_ALLOCATE) && mem_ready_i;
    assign sram_wline_o = mem_rdata_i;

    // plain hit in IDLE, or the joined window in READY
    assign serve = (state_q == S_IDLE && sram_hit_i && !fa_cross_i)
                || (state_q == S_READY && next_q);
    assign proc_stall_o = proc_read_i && !serve;

    always_comb begin
        if (next_q) begin
            // next line halfword 0 above the carried halfword
            proc_rdata_o      = {sram_line_i[HALF_W-1:0], carry_q};
            proc_compressed_o = (carry_q[1:0] != FULL_SIZE_OPCODE);
        end else begin
            proc_rdata_o      = fa_window_i;
            proc_compressed_o = fa_compressed_i;
        end
    end

    // memory sees one address per request
    a_mem_addr_stable: assert property (@(posedge clk) disable iff (proc_reset_i)
        mem_read_o && !mem_ready_i |=> $stable(mem_addr_o));

    // no request left standing once the FSM is back in IDLE
    a_no_read_in_idle: assert property (@(posedge clk) disable iff (proc_reset_i)
        state_q == S_IDLE |-> !mem_read_o);

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ns

module icache_top #(
    parameter int SET_IDX_W = 2
) (
    input  logic                                   clk,
    input  logic                                   proc_reset_i,
    input  logic                                   proc_read_i,
    input  logic [cache_geom_pkg::PROC_ADDR_W-1:0] proc_addr_i,
    output logic [fetch_pkg::WORD_W-1:0]           proc_rdata_o,
    output logic                                   proc_compressed_o,
    output logic                                   proc_stall_o,
    output logic                                   mem_read_o,
    output logic [cache_geom_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
    input  logic [cache_geom_pkg::LINE_W-1:0]      mem_rdata_i,
    input  logic                                   mem_ready_i
);

    import cache_geom_pkg::*;
    import fetch_pkg::*;

    // controller to storage
    logic [MEM_ADDR_W-1:0] sram_addr;
    logic                  sram_write;
    logic [LINE_W-1:0]     sram_wline;
    // storage to controller and aligner
    logic [LINE_W-1:0]     sram_line;
    logic                  sram_hit;
    // aligner handshake
    logic [OFFSET_W-1:0]   fa_offset;
    logic [WORD_W-1:0]     fa_window;
    logic                  fa_compressed;
    logic                  fa_cross;

    icache_controller #(
        .SET_IDX_W (SET_IDX_W)
    ) i_controller (
        .clk               (clk),
        .proc_reset_i      (proc_reset_i),
        .proc_read_i       (proc_read_i),
        .proc_addr_i       (proc_addr_i),
        .proc_rdata_o      (proc_rdata_o),
        .proc_compressed_o (proc_compressed_o),
        .proc_stall_o      (proc_stall_o),
        .mem_read_o        (mem_read_o),
        .mem_addr_o        (mem_addr_o),
        .mem_rdata_i       (mem_rdata_i),
        .mem_ready_i       (mem_ready_i),
        .sram_addr_o       (sram_addr),
        .sram_write_o      (sram_write),
        .sram_wline_o      (sram_wline),
        .sram_hit_i        (sram_hit),
        .sram_line_i       (sram_line),
        .fa_offset_o       (fa_offset),
        .fa_window_i       (fa_window),
        .fa_compressed_i   (fa_compressed),
        .fa_cross_i        (fa_cross)
    );

    fetch_align i_align (
        .line_i       (sram_line),
        .offset_i     (fa_offset),
        .window_o     (fa_window),
        .compressed_o (fa_compressed),
        .cross_o      (fa_cross)
    );

    cache_sram_2way #(
        .SET_IDX_W (SET_IDX_W)
    ) i_sram (
        .clk          (clk),
        .proc_reset_i (proc_reset_i),
        .addr_i       (sram_addr),
        .write_i      (sram_write),
        .wline_i      (sram_wline),
        .rline_o      (sram_line),
        .hit_o        (sram_hit)
    );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ns

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h3bc7
) (
    input  logic                                  clk,
    input  logic                                  mem_read_i,
    input  logic [cache_geom_pkg::MEM_ADDR_W-1:0] mem_addr_i,
    output logic [cache_geom_pkg::LINE_W-1:0]     mem_rdata_o,
    output logic                                  mem_ready_o
);

    import cache_geom_pkg::*;

    logic [31:0] rand_state;
    int          latency;

    // xorshift32 step, never reaches zero from a nonzero seed
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // count field on top, encoding in the low two bits
    // bit 3 of a halfword address is the low bit of its line address
    function automatic logic [15:0] stored_halfword(input logic [PROC_ADDR_W-1:0] a);
        return {a[13:0] + 14'd3, (a[3] ? 2'b01 : 2'b11)};
    endfunction

    function automatic logic [LINE_W-1:0] line_contents(input logic [MEM_ADDR_W-1:0] line);
        logic [LINE_W-1:0] data;
        data = '0;
        for (int h = 0; h < HW_PER_LINE; h++) begin
            data[16*h +: 16] = stored_halfword({line, OFFSET_W'(h)});
        end
        return data;
    endfunction

    initial begin
        rand_state  = SEED;
        mem_ready_o = 1'b0;
        mem_rdata_o = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_read_i) begin
                rand_state = xorshift32(rand_state);
                // 1 to 4 cycles in ALLOCATE
                latency = int'(rand_state[1:0]) + 1;
                repeat (latency - 1) begin
                    @(posedge clk);
                    #1;
                end
                mem_rdata_o = line_contents(mem_addr_i);
                mem_ready_o = 1'b1;
                // ready lasts a single cycle
                @(posedge clk);
                #1;
                mem_ready_o = 1'b0;
                mem_rdata_o = '0;
            end
        end
    end

endmodule

// ==== tb_icache.sv ====
`timescale 1ns/1ns

module tb_icache;

    import cache_geom_pkg::*;
    import fetch_pkg::*;

    localparam int SET_IDX_W    = 2;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int STALL_LIMIT  = 40;
    localparam int N_ACCESS     = 14;
    localparam int ENTRY_W      = 1 + PROC_ADDR_W + 4 + MEM_ADDR_W + 1;

    // columns: reset before, halfword address, memory reads, line of last read, stall
    // set index is line address bits 1..0, lines 10, 14 and 18 share set 0
    localparam logic [ENTRY_W-1:0] ACCESS_TBL [N_ACCESS] = '{
        {1'b0, 31'h082, 4'd1, 28'h10, 1'b1},
        {1'b0, 31'h085, 4'd0, 28'h00, 1'b0},
        {1'b0, 31'h08f, 4'd1, 28'h11, 1'b1},
        {1'b0, 31'h110, 4'd1, 28'h22, 1'b1},
        {1'b0, 31'h117, 4'd1, 28'h23, 1'b1},
        {1'b0, 31'h117, 4'd0, 28'h00, 1'b1},
        {1'b0, 31'h080, 4'd0, 28'h00, 1'b0},
        {1'b0, 31'h0a0, 4'd1, 28'h14, 1'b1},
        {1'b0, 31'h081, 4'd0, 28'h00, 1'b0},
        {1'b0, 31'h0c0, 4'd1, 28'h18, 1'b1},
        {1'b0, 31'h083, 4'd0, 28'h00, 1'b0},
        {1'b0, 31'h0a1, 4'd1, 28'h14, 1'b1},
        {1'b1, 31'h084, 4'd1, 28'h10, 1'b1},
        {1'b0, 31'h117, 4'd2, 28'h23, 1'b1}
    };

    logic                   clk = 1'b0;
    logic                   proc_reset_i;
    logic                   proc_read_i;
    logic [PROC_ADDR_W-1:0] proc_addr_i;
    logic [WORD_W-1:0]      proc_rdata_o;
    logic                   proc_compressed_o;
    logic                   proc_stall_o;
    logic                   mem_read_o;
    logic [MEM_ADDR_W-1:0]  mem_addr_o;
    logic [LINE_W-1:0]      mem_rdata_i;
    logic                   mem_ready_i;

    // read request monitor
    int                     read_count = 0;
    logic                   read_prev = 1'b0;
    logic [MEM_ADDR_W-1:0]  last_read_line = '0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    icache_top #(
        .SET_IDX_W (SET_IDX_W)
    ) i_icache_top (
        .clk               (clk),
        .proc_reset_i      (proc_reset_i),
        .proc_read_i       (proc_read_i),
        .proc_addr_i       (proc_addr_i),
        .proc_rdata_o      (proc_rdata_o),
        .proc_compressed_o (proc_compressed_o),
        .proc_stall_o      (proc_stall_o),
        .mem_read_o        (mem_read_o),
        .mem_addr_o        (mem_addr_o),
        .mem_rdata_i       (mem_rdata_i),
        .mem_ready_i       (mem_ready_i)
    );

    tb_mem_model #(
        .SEED (32'h3bc7)
    ) i_mem (
        .clk         (clk),
        .mem_read_i  (mem_read_o),
        .mem_addr_i  (mem_addr_o),
        .mem_rdata_o (mem_rdata_i),
        .mem_ready_o (mem_ready_i)
    );

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (mem_read_o && !read_prev) begin
            read_count     = read_count + 1;
            last_read_line = mem_addr_o;
        end
        read_prev = mem_read_o;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_on_error($sformatf("** Error: %s = %h, expected %h", name, got, exp));
        end
    endtask

    // memory rule, same formula the model stores
    function automatic logic [HALF_W-1:0] expected_halfword(input logic [PROC_ADDR_W-1:0] a);
        return {a[13:0] + 14'd3, (a[3] ? 2'b01 : 2'b11)};
    endfunction

    task automatic apply_reset();
        proc_reset_i = 1'b1;
        proc_read_i  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        proc_reset_i = 1'b0;
        // quiet fetch unit, so no request and no stall
        repeat (3) begin
            @(negedge clk);
            check_equal("mem_read_o", 32'(mem_read_o), 32'd0);
            check_equal("proc_stall_o", 32'(proc_stall_o), 32'd0);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [ENTRY_W-1:0]     entry;
        logic [PROC_ADDR_W-1:0] addr;
        logic [HALF_W-1:0]      lo;
        logic [WORD_W-1:0]      exp_window;
        logic                   exp_compressed;
        logic                   first_stall;
        int                     reads_before;
        int                     stall_cycles;

        proc_reset_i = 1'b1;
        proc_read_i  = 1'b0;
        proc_addr_i  = '0;
        apply_reset();

        for (int i = 0; i < N_ACCESS; i++) begin
            entry = ACCESS_TBL[i];
            addr  = entry[ENTRY_W-2 -: PROC_ADDR_W];
            if (entry[ENTRY_W-1]) begin
                apply_reset();
            end

            // compressed: zero on top, full size: next halfword on top
            // the next halfword may sit in the following line
            lo             = expected_halfword(addr);
            exp_compressed = (lo[1:0] != FULL_SIZE_OPCODE);
            exp_window     = exp_compressed ? {16'h0000, lo}
                                            : {expected_halfword(addr + 31'd1), lo};

            reads_before = read_count;
            proc_read_i  = 1'b1;
            proc_addr_i  = addr;

            @(negedge clk);
            first_stall  = proc_stall_o;
            stall_cycles = 0;
            while (proc_stall_o) begin
                stall_cycles++;
                assert (stall_cycles < STALL_LIMIT) else begin
                    stop_on_error("access timed out, proc_stall_o never went low");
                end
                @(negedge clk);
            end
            check_equal("proc_rdata_o", proc_rdata_o, exp_window);
            check_equal("proc_compressed_o", 32'(proc_compressed_o), 32'(exp_compressed));
            check_equal("proc_stall_o", 32'(first_stall), 32'(entry[0]));

            @(posedge clk);
            #1;
            check_equal("mem_read_o rising edges", read_count - reads_before,
                        32'(entry[MEM_ADDR_W+4:MEM_ADDR_W+1]));
            if (entry[MEM_ADDR_W+4:MEM_ADDR_W+1] != 4'd0) begin
                check_equal("mem_addr_o", 32'(last_read_line), 32'(entry[MEM_ADDR_W:1]));
            end
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== src.f ====
cache_geom_pkg.sv
fetch_pkg.sv
cache_sram_2way.sv
fetch_align.sv
icache_controller.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= tb_icache
RTL_TOP    ?= icache_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
